//--- hw/ooo_exec_pkg.sv
// shared definitions for the execute stage
// operation codes, tag and data widths, issue and bus packets,
// and the operation-class helper used by dispatch

package ooo_exec_pkg;

  // reorder-buffer tag width
  localparam int rob_tag_w = 4;

  // operand and result width
  localparam int xlen = 32;

  // operation codes, 4 bits wide
  typedef enum logic [3:0] {
    op_add  = 4'd0,
    op_sub  = 4'd1,
    op_and  = 4'd2,
    op_or   = 4'd3,
    op_xor  = 4'd4,
    op_slt  = 4'd5,
    op_sltu = 4'd6,
    op_sll  = 4'd7,
    op_srl  = 4'd8,
    op_sra  = 4'd9
  } alu_op_t;

  // packet from the reservation stations, 72 bits
  typedef struct packed {
    alu_op_t              op;
    logic [xlen-1:0]      a;
    logic [xlen-1:0]      b;
    logic [rob_tag_w-1:0] tag;
  } issue_packet_t;

  // packet on the common data bus, 36 bits
  typedef struct packed {
    logic [rob_tag_w-1:0] tag;
    logic [xlen-1:0]      result;
  } cdb_packet_t;

  // shift ops go to the iterative shifter, everything else to the alu
  function automatic logic is_shift_op(alu_op_t op);
    logic shift_class;
    case (op)
      op_sll,
      op_srl,
      op_sra:  shift_class = 1'b1;
      default: shift_class = 1'b0;
    endcase
    return shift_class;
  endfunction

endpackage

//--- hw/shift_unit.sv
// iterative shift functional unit
// shift_unit wraps a datapath holding operand and count,
// and a control FSM stepping one bit per clock

module shift_unit import ooo_exec_pkg::*; (
  input  logic          clk,
  input  logic          reset,
  input  logic          valid_in,
  input  issue_packet_t issue,
  input  logic          yumi,
  output logic          ready,
  output logic          valid_out,
  output cdb_packet_t   out
);

  logic                 load;
  logic                 step;
  logic [4:0]           count;
  logic [xlen-1:0]      value;
  logic [rob_tag_w-1:0] tag_q;
  alu_op_t              op_q;

  // tag and op held for the whole shift
  always_ff @(posedge clk) begin
    if (load) begin
      tag_q <= issue.tag;
      op_q  <= issue.op;
    end
  end

  shift_datapath datapath_i (
    .clk     (clk),
    .load    (load),
    .step    (step),
    .op      (op_q),
    .operand (issue.a),
    .amount  (issue.b[4:0]),
    .count   (count),
    .value   (value)
  );

  shift_control control_i (
    .clk       (clk),
    .reset     (reset),
    .valid_in  (valid_in),
    .yumi      (yumi),
    .count     (count),
    .load      (load),
    .step      (step),
    .ready     (ready),
    .valid_out (valid_out)
  );

  assign out.tag    = tag_q;
  assign out.result = value;

endmodule

module shift_datapath import ooo_exec_pkg::*; (
  input  logic        clk,
  input  logic        load,
  input  logic        step,
  input  alu_op_t     op,
  input  logic [31:0] operand,
  input  logic [4:0]  amount,
  output logic [4:0]  count,
  output logic [31:0] value
);

  always_ff @(posedge clk) begin
    if (load) begin
      value <= operand;
      count <= amount;
    end else if (step) begin
      case (op)
        op_sll:  value <= {value[30:0], 1'b0};
        // sign fill
        op_sra:  value <= {value[31], value[31:1]};
        default: value <= {1'b0, value[31:1]};
      endcase
      count <= count - 5'd1;
    end
  end

endmodule

module shift_control (
  input  logic       clk,
  input  logic       reset,
  input  logic       valid_in,
  input  logic       yumi,
  input  logic [4:0] count,
  output logic       load,
  output logic       step,
  output logic       ready,
  output logic       valid_out
);

  typedef enum logic [1:0] {s_idle, s_shift, s_done} state_t;

  state_t state;
  state_t state_next;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= s_idle;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      s_idle:  if (valid_in) state_next = s_shift;
      // zero count means the operand is final
      s_shift: if (count == 5'd0) state_next = s_done;
      s_done:  if (yumi) state_next = s_idle;
      default: state_next = s_idle;
    endcase
  end

  // valid_in is already gated by ready in dispatch
  assign load      = valid_in;
  assign step      = (state == s_shift) && (count != 5'd0);
  assign ready     = (state == s_idle);
  assign valid_out = (state == s_done);

endmodule

//--- hw/alu_unit.sv
// single-cycle arithmetic/logic functional unit
// result and tag held in a register until the bus takes them

module alu_unit import ooo_exec_pkg::*; (
  input  logic          clk,
  input  logic          reset,
  input  logic          valid_in,
  input  issue_packet_t issue,
  input  logic          yumi,
  output logic          ready,
  output logic          valid_out,
  output cdb_packet_t   out
);

  logic [xlen-1:0] result;

  always_comb begin
    case (issue.op)
      op_add:  result = issue.a + issue.b;
      op_sub:  result = issue.a - issue.b;
      op_and:  result = issue.a & issue.b;
      op_or:   result = issue.a | issue.b;
      op_xor:  result = issue.a ^ issue.b;
      op_slt: begin
        result = {{(xlen-1){1'b0}}, ($signed(issue.a) < $signed(issue.b))};
      end
      op_sltu: begin
        result = {{(xlen-1){1'b0}}, (issue.a < issue.b)};
      end
      // shift ops never reach this unit
      default: result = '0;
    endcase
  end

  // result register
  always_ff @(posedge clk) begin
    if (valid_in) begin
      out.tag    <= issue.tag;
      out.result <= result;
    end
  end

  // valid flag
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_out <= 1'b0;
    end else if (valid_in) begin
      valid_out <= 1'b1;
    end else if (yumi) begin
      valid_out <= 1'b0;
    end
  end

  // free again in the cycle the bus takes the result
  assign ready = !valid_out || yumi;

endmodule

//--- hw/fu_dispatch.sv
// issue dispatch between the alu and the shift unit
// classifies the op, steers the strobe and returns ready

module fu_dispatch import ooo_exec_pkg::*; (
  input  logic          issue_valid,
  input  issue_packet_t issue,
  input  logic          alu_ready,
  input  logic          shift_ready,
  output logic          issue_ready,
  output logic          alu_valid_in,
  output logic          shift_valid_in
);

  logic to_shift;
  logic to_alu;
  logic accept;

  // op class picks the unit
  assign to_shift = is_shift_op(issue.op);
  assign to_alu   = !to_shift;

  // back-pressure from the selected unit only
  assign issue_ready = to_shift ? shift_ready : alu_ready;

  assign accept = issue_valid && issue_ready;

  // strobe reaches the selected unit only
  assign alu_valid_in   = accept && to_alu;
  assign shift_valid_in = accept && to_shift;

endmodule

//--- hw/cdb_arbiter.sv
// common data bus arbiter
// two-way round-robin grant with a last-winner register,
// yumi pulses back to the units and the bus mux

module cdb_arbiter import ooo_exec_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        alu_valid,
  input  logic        shift_valid,
  input  cdb_packet_t alu_out,
  input  cdb_packet_t shift_out,
  output logic        alu_yumi,
  output logic        shift_yumi,
  output logic        cdb_valid,
  output cdb_packet_t cdb
);

  logic last_was_shift;
  logic grant_alu;
  logic grant_shift;
  logic contend;

  assign contend = alu_valid && shift_valid;

  // on contention the unit that did not win last time goes first
  always_comb begin
    grant_alu   = 1'b0;
    grant_shift = 1'b0;
    if (contend) begin
      if (last_was_shift) begin
        grant_alu = 1'b1;
      end else begin
        grant_shift = 1'b1;
      end
    end else begin
      grant_alu   = alu_valid;
      grant_shift = shift_valid;
    end
  end

  // last winner, alu goes first after reset
  always_ff @(posedge clk) begin
    if (reset) begin
      last_was_shift <= 1'b1;
    end else if (grant_alu || grant_shift) begin
      last_was_shift <= grant_shift;
    end
  end

  assign alu_yumi   = grant_alu;
  assign shift_yumi = grant_shift;

  // the bus always takes the granted result
  assign cdb_valid = alu_valid || shift_valid;
  assign cdb       = grant_shift ? shift_out : alu_out;

endmodule

//--- hw/exec_stage.sv
// execute stage top level
// dispatch, alu, iterative shifter and the bus arbiter

module exec_stage import ooo_exec_pkg::*; (
  input  logic          clk,
  input  logic          reset,
  input  logic          issue_valid,
  input  issue_packet_t issue,
  output logic          issue_ready,
  output logic          cdb_valid,
  output cdb_packet_t   cdb
);

  logic        alu_valid_in;
  logic        alu_ready;
  logic        alu_valid_out;
  logic        alu_yumi;
  cdb_packet_t alu_out;

  logic        shift_valid_in;
  logic        shift_ready;
  logic        shift_valid_out;
  logic        shift_yumi;
  cdb_packet_t shift_out;

  fu_dispatch dispatch_i (
    .issue_valid    (issue_valid),
    .issue          (issue),
    .alu_ready      (alu_ready),
    .shift_ready    (shift_ready),
    .issue_ready    (issue_ready),
    .alu_valid_in   (alu_valid_in),
    .shift_valid_in (shift_valid_in)
  );

  alu_unit alu_i (
    .clk       (clk),
    .reset     (reset),
    .valid_in  (alu_valid_in),
    .issue     (issue),
    .yumi      (alu_yumi),
    .ready     (alu_ready),
    .valid_out (alu_valid_out),
    .out       (alu_out)
  );

  shift_unit shift_i (
    .clk       (clk),
    .reset     (reset),
    .valid_in  (shift_valid_in),
    .issue     (issue),
    .yumi      (shift_yumi),
    .ready     (shift_ready),
    .valid_out (shift_valid_out),
    .out       (shift_out)
  );

  cdb_arbiter arbiter_i (
    .clk         (clk),
    .reset       (reset),
    .alu_valid   (alu_valid_out),
    .shift_valid (shift_valid_out),
    .alu_out     (alu_out),
    .shift_out   (shift_out),
    .alu_yumi    (alu_yumi),
    .shift_yumi  (shift_yumi),
    .cdb_valid   (cdb_valid),
    .cdb         (cdb)
  );

endmodule

//--- testbench/exec_ref.svh
// reference model for the execute stage testbench
// expected result of each operation and its functional-unit class

`ifndef exec_ref_svh
`define exec_ref_svh

// ops that belong to the shifter
function automatic logic expected_is_shift(alu_op_t op);
  return (op == op_sll) || (op == op_srl) || (op == op_sra);
endfunction

// architectural result of one operation
function automatic logic [31:0] expected_result(alu_op_t op, logic [31:0] a, logic [31:0] b);
  logic [4:0]  amount;
  logic [31:0] res;
  // shifts use the low five bits of b only
  amount = b[4:0];
  case (op)
    op_add:  res = a + b;
    op_sub:  res = a - b;
    op_and:  res = a & b;
    op_or:   res = a | b;
    op_xor:  res = a ^ b;
    op_slt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    op_sltu: res = (a < b) ? 32'd1 : 32'd0;
    op_sll:  res = a << amount;
    op_srl:  res = a >> amount;
    // arithmetic shift fills with the sign bit
    op_sra:  res = $signed(a) >>> amount;
    default: res = '0;
  endcase
  return res;
endfunction

`endif

//--- testbench/exec_stage_tb.sv
// testbench for the execute stage
// directed and random issue driver, tag scoreboard with reference results,
// bus and ready checks, timeout and the closing summary

module exec_stage_tb import ooo_exec_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  `include "exec_ref.svh"

  logic          clk = 1'b0;
  logic          reset;
  logic          issue_valid = 1'b0;
  issue_packet_t issue = '0;
  logic          issue_ready;
  logic          cdb_valid;
  cdb_packet_t   cdb;

  // stimulus, written by the driver side
  issue_packet_t        stim_q[$];
  int                   next_idx;
  int                   issued_count;
  int                   issue_gen [2**rob_tag_w];
  logic [xlen-1:0]      exp_result [2**rob_tag_w];
  alu_op_t              tag_op [2**rob_tag_w];
  int                   tag_seq [2**rob_tag_w];
  int                   shift_issued;
  int                   alu_issued;
  logic [rob_tag_w-1:0] alu_tag;

  // completion side, written by the bus checker
  int done_gen [2**rob_tag_w];
  int completed_count;
  int shift_done;
  int alu_done;
  int max_done_seq = -1;
  int ooo_count;
  int mismatch_count;
  int problem_count;

  int cycle_count;
  int timeout_limit;

  exec_stage dut_i (
    .clk         (clk),
    .reset       (reset),
    .issue_valid (issue_valid),
    .issue       (issue),
    .issue_ready (issue_ready),
    .cdb_valid   (cdb_valid),
    .cdb         (cdb)
  );

  always #50 clk = ~clk;

  task automatic report_mismatch(string msg);
    mismatch_count++;
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
  endtask

  task automatic report_problem(string msg);
    problem_count++;
    $display("error at %0t ns: %s", $time, msg);
  endtask

  function automatic void add_stim(alu_op_t op, logic [xlen-1:0] a, logic [xlen-1:0] b);
    issue_packet_t pkt;
    pkt.op  = op;
    pkt.a   = a;
    pkt.b   = b;
    pkt.tag = '0;
    stim_q.push_back(pkt);
  endfunction

  function automatic void build_stimulus();
    logic [3:0] op_bits;
    // shift amounts 0, 1 and 31 on a negative operand, upper bits of b set
    add_stim(op_sll, 32'h8000_00f1, 32'h0000_0020);
    add_stim(op_sll, 32'h8000_00f1, 32'h0000_0021);
    add_stim(op_sll, 32'h8000_00f1, 32'hffff_ffdf);
    add_stim(op_srl, 32'h8000_00f1, 32'h0000_0020);
    add_stim(op_srl, 32'h8000_00f1, 32'h0000_0021);
    add_stim(op_srl, 32'h8000_00f1, 32'hffff_ffdf);
    add_stim(op_sra, 32'h8000_00f1, 32'h0000_0020);
    add_stim(op_sra, 32'h8000_00f1, 32'h0000_0021);
    add_stim(op_sra, 32'h8000_00f1, 32'hffff_ffdf);
    // long shift followed by alu ops that should overtake it
    add_stim(op_sra, 32'h9abc_def0, 32'd31);
    add_stim(op_add, 32'h0000_0005, 32'h0000_0007);
    add_stim(op_sub, 32'h0000_0005, 32'h0000_0007);
    add_stim(op_xor, 32'h1234_5678, 32'hffff_0000);
    add_stim(op_slt, 32'hffff_fffe, 32'h0000_0003);
    // every op once on the same operands
    for (int i = 0; i < 10; i++) begin
      add_stim(alu_op_t'(4'(i)), 32'hf0f0_1234, 32'h0f0f_8003);
    end
    // signed against unsigned compare and wrap-around
    add_stim(op_slt, 32'hffff_ffff, 32'h0000_0001);
    add_stim(op_slt, 32'h0000_0001, 32'hffff_ffff);
    add_stim(op_sltu, 32'hffff_ffff, 32'h0000_0001);
    add_stim(op_sltu, 32'h0000_0001, 32'hffff_ffff);
    add_stim(op_slt, 32'h8000_0000, 32'h7fff_ffff);
    add_stim(op_sltu, 32'h8000_0000, 32'h7fff_ffff);
    add_stim(op_add, 32'h7fff_ffff, 32'h0000_0001);
    add_stim(op_sub, 32'h0000_0000, 32'h0000_0001);
    repeat (150) begin
      op_bits = 4'($urandom_range(0, 9));
      add_stim(alu_op_t'(op_bits), $urandom, $urandom);
    end
  endfunction

  function automatic logic is_outstanding(logic [rob_tag_w-1:0] tag);
    return issue_gen[tag] != done_gen[tag];
  endfunction

  function automatic logic [rob_tag_w-1:0] lowest_free_tag();
    logic [rob_tag_w-1:0] tag;
    tag = '0;
    for (int i = 2**rob_tag_w - 1; i >= 0; i--) begin
      if (!is_outstanding(rob_tag_w'(i))) begin
        tag = rob_tag_w'(i);
      end
    end
    return tag;
  endfunction

  task automatic record_issue(issue_packet_t pkt);
    issue_gen[pkt.tag]++;
    exp_result[pkt.tag] = expected_result(pkt.op, pkt.a, pkt.b);
    tag_op[pkt.tag]     = pkt.op;
    tag_seq[pkt.tag]    = issued_count;
    issued_count++;
    if (expected_is_shift(pkt.op)) begin
      shift_issued++;
    end else begin
      alu_issued++;
      alu_tag = pkt.tag;
    end
  endtask

  task automatic check_bus_result(cdb_packet_t pkt);
    alu_op_t op;
    op = tag_op[pkt.tag];
    assert (is_outstanding(pkt.tag)) else
      report_problem($sformatf("bus result for tag %0d, which is not outstanding", pkt.tag));
    if (is_outstanding(pkt.tag)) begin
      assert (pkt.result === exp_result[pkt.tag]) else
        report_mismatch($sformatf("tag %0d %s result %h, expected %h",
                                  pkt.tag, op.name(), pkt.result, exp_result[pkt.tag]));
      // an earlier issue finishing after a later one
      if (tag_seq[pkt.tag] < max_done_seq) begin
        ooo_count++;
      end else begin
        max_done_seq = tag_seq[pkt.tag];
      end
      done_gen[pkt.tag]++;
      completed_count++;
      if (expected_is_shift(op)) begin
        shift_done++;
      end else begin
        alu_done++;
      end
    end
  endtask

  // driver, holds a packet until it is accepted
  always @(posedge clk) begin
    issue_packet_t pkt;
    if (reset) begin
      issue_valid <= 1'b0;
    end else begin
      if (issue_valid && issue_ready) begin
        record_issue(issue);
      end
      if (!issue_valid || issue_ready) begin
        if (next_idx < stim_q.size() && $urandom_range(0, 3) != 0) begin
          pkt     = stim_q[next_idx];
          pkt.tag = lowest_free_tag();
          next_idx++;
          issue       <= pkt;
          issue_valid <= 1'b1;
        end else begin
          issue_valid <= 1'b0;
        end
      end
    end
  end

  // bus and ready checks, sampled mid-cycle
  always @(negedge clk) begin
    logic    exp_ready;
    alu_op_t cur_op;
    cur_op = issue.op;
    if (reset) begin
      assert (cdb_valid === 1'b0) else report_mismatch("cdb_valid high during reset");
      assert (issue_ready === 1'b1) else report_mismatch("issue_ready low during reset");
    end else begin
      if (expected_is_shift(cur_op)) begin
        exp_ready = (shift_issued == shift_done);
      end else begin
        // alu frees up in the cycle its result is on the bus
        exp_ready = (alu_issued == alu_done) || (cdb_valid === 1'b1 && cdb.tag == alu_tag);
      end
      assert (issue_ready === exp_ready) else
        report_mismatch($sformatf("issue_ready %b for %s, expected %b",
                                  issue_ready, cur_op.name(), exp_ready));
      if (issued_count == completed_count) begin
        assert (cdb_valid === 1'b0) else
          report_mismatch("cdb_valid high with no operation outstanding");
      end
      if (cdb_valid === 1'b1) begin
        check_bus_result(cdb);
      end
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= timeout_limit) begin
      $display("timeout: run stopped after %0d cycles, %0d of %0d issues completed",
               cycle_count, completed_count, stim_q.size());
      $display("Result: FAILED");
      $finish;
    end
  end

  initial begin
    int unsigned seed_draw;
    reset     = 1'b1;
    seed_draw = $urandom(32'h5bc2_a9e6);
    build_stimulus();
    timeout_limit = 40 * stim_q.size();
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    while (!(next_idx == stim_q.size() && issue_valid === 1'b0 &&
             completed_count == issued_count)) begin
      @(negedge clk);
    end
    // idle tail so the quiet bus is checked too
    repeat (5) @(posedge clk);
    assert (ooo_count > 0) else report_problem("no result completed ahead of an earlier issue");
    $display("issued %0d, completed %0d, out of order %0d, value errors %0d, other errors %0d",
             issued_count, completed_count, ooo_count, mismatch_count, problem_count);
    if (mismatch_count == 0 && problem_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

//--- exec_stage.f
+incdir+testbench
hw/ooo_exec_pkg.sv
hw/shift_unit.sv
hw/alu_unit.sv
hw/fu_dispatch.sv
hw/cdb_arbiter.sv
hw/exec_stage.sv
testbench/exec_stage_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile the execute stage testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f exec_stage.f --top-module exec_stage_tb \
  -Mdir "$build_dir" -o exec_stage_sim
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

"./$build_dir/exec_stage_sim" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "Result: PASSED" "$log_file"; then
  echo "simulation passed"
  exit 0
fi

echo "simulation failed"
exit 1
